// ==== sim.f ====
+incdir+logic
logic/aud_pkg.sv
logic/aud_ctrl.sv
logic/aud_recorder.sv
logic/aud_player.sv
logic/sram_arbiter.sv
logic/aud_top.sv
test/sram_model.sv
test/aud_assert.sv
test/tb_aud_top.sv

// ==== test/tb_aud_top.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module tb_aud_top import aud_pkg::*; ();

	localparam int rec_len = 40;

	logic                   clk = 1'b0;
	logic                   arst_n;
	logic                   key_record;
	logic                   key_play;
	logic                   key_stop;
	aud_speed_t             speed;
	logic                   is_slow;
	logic                   aud_bclk;
	logic                   aud_lrck;
	logic                   aud_adcdat;
	logic                   aud_dacdat;
	logic [`AUD_ADDR_W-1:0] sram_addr;
	logic                   sram_we_n;
	logic                   sram_oe_n;
	logic [`AUD_DATA_W-1:0] sram_wdata;
	logic [`AUD_DATA_W-1:0] sram_rdata;
	aud_state_e             state;

	logic [8:0]             tick;
	int                     frame_no;
	int                     gen_frame;
	logic [31:0]            lfsr;
	logic [15:0]            cur_word;
	logic                   prev_lsb;
	logic [15:0]            left_s [0:1023];
	logic [15:0]            dac_left;
	logic [15:0]            dac_right;
	logic [15:0]            exp_word;
	logic [15:0]            exp_q [$];
	logic                   chk_on;
	int                     chk_from;
	int                     rec_base;
	int                     wr_cnt;
	int                     err_cnt;
	int                     test_cnt;
	int                     pass_cnt;
	int                     err_before;
	int                     wr_seen;
	int                     assert_seen;
	logic                   abort;

	aud_top u_dut (
		.i_clk         (clk),
		.i_arst_n      (arst_n),
		.i_key_record  (key_record),
		.i_key_play    (key_play),
		.i_key_stop    (key_stop),
		.i_speed       (speed),
		.i_is_slow     (is_slow),
		.i_aud_bclk    (aud_bclk),
		.i_aud_adclrck (aud_lrck),
		.i_aud_adcdat  (aud_adcdat),
		.i_aud_daclrck (aud_lrck),
		.o_aud_dacdat  (aud_dacdat),
		.o_sram_addr   (sram_addr),
		.o_sram_we_n   (sram_we_n),
		.o_sram_oe_n   (sram_oe_n),
		.o_sram_wdata  (sram_wdata),
		.i_sram_rdata  (sram_rdata),
		.o_state       (state)
	);

	sram_model u_sram (
		.i_clk   (clk),
		.i_addr  (sram_addr),
		.i_we_n  (sram_we_n),
		.i_oe_n  (sram_oe_n),
		.i_wdata (sram_wdata),
		.o_rdata (sram_rdata)
	);

	bind sram_arbiter aud_assert u_assert (.*);

	initial begin
		forever #50 clk = ~clk;
	end

	// galois lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// expected sram address of the n-th fetch after play starts
	function automatic int ref_addr(input int n, input int spd, input logic slow);
		if (slow) begin
			return n / (spd + 1);
		end
		return n * (spd + 1);
	endfunction

	task automatic make_word(output logic [15:0] w);
		int b;
		w = '0;
		for (b = 0; b < 16; b++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[14:0], lfsr[0]};
		end
	endtask

	// bclk is clk/16 and a frame is 32 bclk with lrck low for left
	always @(negedge clk) begin
		tick     <= tick + 1'b1;
		aud_bclk <= tick[3];
		aud_lrck <= tick[8];
		if (tick[7:0] == 8'd0) begin
			prev_lsb = cur_word[0];
			make_word(cur_word);
			if (!tick[8]) begin
				gen_frame = gen_frame + 1;
				frame_no <= gen_frame;
				if (gen_frame < 1024) begin
					left_s[gen_frame] = cur_word;
				end
			end
		end
		// lsb of the previous slot goes out during the delay bit
		if (tick[3:0] == 4'd0) begin
			if (tick[7:4] == 4'd0) begin
				aud_adcdat <= prev_lsb;
			end else begin
				aud_adcdat <= cur_word[16 - tick[7:4]];
			end
		end
	end

	// dac bits are sampled where bclk rises
	always @(negedge clk) begin
		if (tick[3:0] == 4'd8) begin
			if (tick[7:4] != 4'd0) begin
				if (!tick[8]) begin
					dac_left[16 - tick[7:4]] = aud_dacdat;
				end else begin
					dac_right[16 - tick[7:4]] = aud_dacdat;
				end
			end else if (tick[8]) begin
				dac_left[0] = aud_dacdat;
				if (chk_on && frame_no >= chk_from && exp_q.size() > 0) begin
					exp_word = exp_q.pop_front();
					if (dac_left !== exp_word) begin
						$display("[ERROR] %0t o_aud_dacdat left frame %0d: expected %h, got %h",
							$time, frame_no, exp_word, dac_left);
						err_cnt++;
					end
				end
			end else begin
				dac_right[0] = aud_dacdat;
				if (chk_on && dac_right !== 16'h0000) begin
					$display("[ERROR] %0t o_aud_dacdat right slot: expected 0000, got %h",
						$time, dac_right);
					err_cnt++;
				end
			end
		end
	end

	// sram pin monitor
	always @(negedge clk) begin
		if (arst_n && !sram_we_n) begin
			if (sram_addr !== wr_cnt) begin
				$display("[ERROR] %0t o_sram_addr: expected %0d, got %0d",
					$time, wr_cnt, sram_addr);
				err_cnt++;
			end
			if (sram_wdata !== left_s[rec_base + wr_cnt]) begin
				$display("[ERROR] %0t o_sram_wdata: expected %h, got %h",
					$time, left_s[rec_base + wr_cnt], sram_wdata);
				err_cnt++;
			end
			wr_cnt = wr_cnt + 1;
		end
		if (arst_n && !sram_oe_n && state == st_pause) begin
			$display("sram read issued while paused at %0t", $time);
			err_cnt++;
		end
	end

	task automatic wait_mid(input int f);
		int n;
		n = 0;
		while (!abort && !(frame_no == f && tick == 9'd128)) begin
			@(negedge clk);
			n++;
			if (n > 60000) begin
				$display("timeout waiting for the middle of frame %0d", f);
				abort = 1'b1;
			end
		end
	endtask

	task automatic wait_state(input aud_state_e st);
		int n;
		n = 0;
		while (!abort && state != st) begin
			@(negedge clk);
			n++;
			if (n > 120000) begin
				$display("timeout waiting for state %s", st.name());
				abort = 1'b1;
			end
		end
	endtask

	task automatic wait_writes(input int cnt);
		int n;
		n = 0;
		while (!abort && wr_cnt < cnt) begin
			@(negedge clk);
			n++;
			if (n > 60000) begin
				$display("timeout waiting for %0d sram writes", cnt);
				abort = 1'b1;
			end
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (!abort && exp_q.size() > 0) begin
			@(negedge clk);
			n++;
			if (n > 3000) begin
				$display("timeout waiting for the last expected dac frames");
				abort = 1'b1;
			end
		end
	endtask

	task automatic press_key(input logic rec, input logic play, input logic stop);
		key_record <= rec;
		key_play   <= play;
		key_stop   <= stop;
		@(negedge clk);
		key_record <= 1'b0;
		key_play   <= 1'b0;
		key_stop   <= 1'b0;
	endtask

	task automatic end_test(input string name);
		int new_fails;
		new_fails = u_dut.u_arbiter.u_assert.fail_cnt - assert_seen;
		if (new_fails != 0) begin
			$display("%0d assertion failures in the sram arbiter checker", new_fails);
			err_cnt     = err_cnt + new_fails;
			assert_seen = assert_seen + new_fails;
		end
		test_cnt++;
		if (!abort && err_cnt == err_before) begin
			pass_cnt++;
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
		end
		err_before = err_cnt;
	endtask

	// pause_len frames of silence start after pause_at played frames
	task automatic run_play(input aud_speed_t spd, input logic slow,
		input int pause_at, input int pause_len);
		logic [15:0] seq [$];
		int n;
		int a;
		int j;
		int start;
		seq.push_back(16'h0000);
		n = 0;
		a = ref_addr(0, int'(spd), slow);
		while (a < rec_len) begin
			seq.push_back(left_s[rec_base + a]);
			n++;
			a = ref_addr(n, int'(spd), slow);
		end
		exp_q.delete();
		for (j = 0; j < seq.size(); j++) begin
			if (j == pause_at && pause_len > 0) begin
				repeat (pause_len) exp_q.push_back(16'h0000);
			end
			exp_q.push_back(seq[j]);
		end
		exp_q.push_back(16'h0000);
		wait_mid(frame_no + 1);
		speed    <= spd;
		is_slow  <= slow;
		start    = frame_no + 1;
		chk_from = start;
		chk_on   = 1'b1;
		press_key(1'b0, 1'b1, 1'b0);
		if (pause_len > 0) begin
			wait_mid(start + pause_at - 1);
			press_key(1'b0, 1'b1, 1'b0);
			if (!abort && state != st_pause) begin
				$display("[ERROR] %0t o_state: expected st_pause, got %s",
					$time, state.name());
				err_cnt++;
			end
			wait_mid(start + pause_at - 1 + pause_len);
			press_key(1'b0, 1'b1, 1'b0);
		end
		wait_state(st_idle);
		// last sample and the silent frame after it are still to come
		if (!abort && exp_q.size() != 2) begin
			$display("playback stopped with %0d frames still expected, not 2", exp_q.size());
			err_cnt++;
		end
		wait_drain();
		chk_on = 1'b0;
	endtask

	initial begin
		arst_n      = 1'b0;
		key_record  = 1'b0;
		key_play    = 1'b0;
		key_stop    = 1'b0;
		speed       = '0;
		is_slow     = 1'b0;
		aud_bclk    = 1'b0;
		aud_lrck    = 1'b1;
		aud_adcdat  = 1'b0;
		tick        = '0;
		frame_no    = -1;
		gen_frame   = -1;
		lfsr        = 32'h22fe_6a3f;
		cur_word    = '0;
		prev_lsb    = 1'b0;
		chk_on      = 1'b0;
		chk_from    = 0;
		rec_base    = 0;
		wr_cnt      = 0;
		err_cnt     = 0;
		err_before  = 0;
		test_cnt    = 0;
		pass_cnt    = 0;
		assert_seen = 0;
		abort       = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n <= 1'b1;

		wait_mid(3);
		rec_base = frame_no;
		press_key(1'b1, 1'b0, 1'b0);
		wait_writes(rec_len);
		wait_mid(rec_base + rec_len);
		press_key(1'b0, 1'b0, 1'b1);
		end_test("record 40 frames");

		if (!abort) begin
			wait_state(st_idle);
			wr_seen = wr_cnt;
			wait_mid(frame_no + 5);
			if (wr_cnt != wr_seen || wr_cnt != rec_len) begin
				$display("[ERROR] %0t sram write count: expected %0d, got %0d",
					$time, rec_len, wr_cnt);
				err_cnt++;
			end
			end_test("stop then idle");
		end
		if (!abort) begin
			run_play(3'd0, 1'b0, 0, 0);
			end_test("play factor 1");
		end
		if (!abort) begin
			run_play(3'd2, 1'b0, 0, 0);
			end_test("play fast speed 2");
		end
		if (!abort) begin
			run_play(3'd1, 1'b1, 0, 0);
			end_test("play slow speed 1");
		end
		if (!abort) begin
			run_play(3'd0, 1'b0, 10, 4);
			end_test("pause and resume");
		end

		$display("%0d tests run, %0d passed, %0d errors", test_cnt, pass_cnt, err_cnt);
		if (err_cnt == 0 && !abort) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== test/aud_assert.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module aud_assert (
	input logic                   i_clk,
	input logic                   i_arst_n,
	input logic                   i_wr_valid,
	input logic [`AUD_ADDR_W-1:0] i_wr_addr,
	input logic [`AUD_DATA_W-1:0] i_wr_data,
	input logic                   o_wr_ready,
	input logic                   i_rd_valid,
	input logic [`AUD_ADDR_W-1:0] i_rd_addr,
	input logic                   o_rd_ready,
	input logic                   o_rd_rvalid,
	input logic                   o_sram_we_n,
	input logic                   o_sram_oe_n
);

	int fail_cnt = 0;

	a_one_grant: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_wr_ready && o_rd_ready))
		else begin
			$error("write and read granted in the same cycle");
			fail_cnt++;
		end

	// a waiting request keeps its valid and its payload
	a_wr_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_wr_valid && !o_wr_ready) |=> (i_wr_valid && $stable(i_wr_addr) && $stable(i_wr_data)))
		else begin
			$error("write request changed before its grant");
			fail_cnt++;
		end

	a_rd_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(i_rd_valid && !o_rd_ready) |=> (i_rd_valid && $stable(i_rd_addr)))
		else begin
			$error("read request changed before its grant");
			fail_cnt++;
		end

	a_we_oe: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(!o_sram_we_n && !o_sram_oe_n))
		else begin
			$error("sram write and output enable both active");
			fail_cnt++;
		end

	a_rvalid_lat: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_rd_ready |-> ##2 o_rd_rvalid)
		else begin
			$error("read data valid missing two cycles after grant");
			fail_cnt++;
		end

	a_rvalid_src: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_rd_rvalid |-> $past(o_rd_ready, 2))
		else begin
			$error("read data valid without a read grant");
			fail_cnt++;
		end

endmodule

// ==== test/sram_model.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module sram_model (
	input  logic                   i_clk,
	input  logic [`AUD_ADDR_W-1:0] i_addr,
	input  logic                   i_we_n,
	input  logic                   i_oe_n,
	input  logic [`AUD_DATA_W-1:0] i_wdata,
	output logic [`AUD_DATA_W-1:0] o_rdata
);

	// full word address range of the board sram
	logic [`AUD_DATA_W-1:0] mem [0:(1 << `AUD_ADDR_W) - 1];

	// read data comes out one cycle after the registered read pins
	always_ff @(posedge i_clk) begin
		if (!i_we_n) begin
			mem[i_addr] <= i_wdata;
		end
		if (!i_oe_n) begin
			o_rdata <= mem[i_addr];
		end
	end

endmodule

// ==== logic/aud_top.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module aud_top import aud_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_key_record,
	input  logic                   i_key_play,
	input  logic                   i_key_stop,
	input  aud_speed_t             i_speed,
	input  logic                   i_is_slow,
	input  logic                   i_aud_bclk,
	input  logic                   i_aud_adclrck,
	input  logic                   i_aud_adcdat,
	input  logic                   i_aud_daclrck,
	output logic                   o_aud_dacdat,
	output logic [`AUD_ADDR_W-1:0] o_sram_addr,
	output logic                   o_sram_we_n,
	output logic                   o_sram_oe_n,
	output logic [`AUD_DATA_W-1:0] o_sram_wdata,
	input  logic [`AUD_DATA_W-1:0] i_sram_rdata,
	output aud_state_e             o_state
);

	logic [`AUD_ADDR_W-1:0] end_addr;
	logic [`AUD_ADDR_W-1:0] rec_addr;
	logic                   play_done;
	logic                   wr_valid;
	logic                   wr_ready;
	logic [`AUD_ADDR_W-1:0] wr_addr;
	logic [`AUD_DATA_W-1:0] wr_data;
	logic                   rd_valid;
	logic                   rd_ready;
	logic [`AUD_ADDR_W-1:0] rd_addr;
	logic [`AUD_DATA_W-1:0] rd_data;
	logic                   rd_rvalid;

	aud_ctrl u_ctrl (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_key_record (i_key_record),
		.i_key_play   (i_key_play),
		.i_key_stop   (i_key_stop),
		.i_rec_addr   (rec_addr),
		.i_play_done  (play_done),
		.o_state      (o_state),
		.o_end_addr   (end_addr)
	);

	// adc side
	aud_recorder u_recorder (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_state       (o_state),
		.i_aud_bclk    (i_aud_bclk),
		.i_aud_adclrck (i_aud_adclrck),
		.i_aud_adcdat  (i_aud_adcdat),
		.i_wr_ready    (wr_ready),
		.o_wr_valid    (wr_valid),
		.o_wr_addr     (wr_addr),
		.o_wr_data     (wr_data),
		.o_rec_addr    (rec_addr)
	);

	// dac side
	aud_player u_player (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_state       (o_state),
		.i_speed       (i_speed),
		.i_is_slow     (i_is_slow),
		.i_end_addr    (end_addr),
		.i_aud_bclk    (i_aud_bclk),
		.i_aud_daclrck (i_aud_daclrck),
		.i_rd_ready    (rd_ready),
		.i_rd_data     (rd_data),
		.i_rd_rvalid   (rd_rvalid),
		.o_rd_valid    (rd_valid),
		.o_rd_addr     (rd_addr),
		.o_aud_dacdat  (o_aud_dacdat),
		.o_play_done   (play_done)
	);

	sram_arbiter u_arbiter (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_wr_valid   (wr_valid),
		.i_wr_addr    (wr_addr),
		.i_wr_data    (wr_data),
		.o_wr_ready   (wr_ready),
		.i_rd_valid   (rd_valid),
		.i_rd_addr    (rd_addr),
		.o_rd_ready   (rd_ready),
		.o_rd_data    (rd_data),
		.o_rd_rvalid  (rd_rvalid),
		.o_sram_addr  (o_sram_addr),
		.o_sram_we_n  (o_sram_we_n),
		.o_sram_oe_n  (o_sram_oe_n),
		.o_sram_wdata (o_sram_wdata),
		.i_sram_rdata (i_sram_rdata)
	);

endmodule

// ==== logic/sram_arbiter.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module sram_arbiter (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_wr_valid,
	input  logic [`AUD_ADDR_W-1:0] i_wr_addr,
	input  logic [`AUD_DATA_W-1:0] i_wr_data,
	output logic                   o_wr_ready,
	input  logic                   i_rd_valid,
	input  logic [`AUD_ADDR_W-1:0] i_rd_addr,
	output logic                   o_rd_ready,
	output logic [`AUD_DATA_W-1:0] o_rd_data,
	output logic                   o_rd_rvalid,
	output logic [`AUD_ADDR_W-1:0] o_sram_addr,
	output logic                   o_sram_we_n,
	output logic                   o_sram_oe_n,
	output logic [`AUD_DATA_W-1:0] o_sram_wdata,
	input  logic [`AUD_DATA_W-1:0] i_sram_rdata
);

	// last winner was the write side
	logic       last_wr;
	logic [1:0] rd_tag;

	// round robin, the side that lost last time goes first
	assign o_wr_ready = i_wr_valid && (!i_rd_valid || !last_wr);
	assign o_rd_ready = i_rd_valid && !o_wr_ready;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_sram_we_n <= 1'b1;
			o_sram_oe_n <= 1'b1;
			last_wr     <= 1'b0;
			rd_tag      <= '0;
		end else begin
			o_sram_we_n <= !o_wr_ready;
			o_sram_oe_n <= !o_rd_ready;
			// stage 0 is the pin cycle, stage 1 the sram output cycle
			rd_tag      <= {rd_tag[0], o_rd_ready};
			if (o_wr_ready) begin
				last_wr <= 1'b1;
			end else if (o_rd_ready) begin
				last_wr <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_wr_ready) begin
			o_sram_addr  <= i_wr_addr;
			o_sram_wdata <= i_wr_data;
		end else if (o_rd_ready) begin
			o_sram_addr <= i_rd_addr;
		end
	end

	// sram output is already registered, so it lines up with tag stage 1
	assign o_rd_rvalid = rd_tag[1];
	assign o_rd_data   = i_sram_rdata;

endmodule

// ==== logic/aud_player.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module aud_player import aud_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  aud_state_e             i_state,
	input  aud_speed_t             i_speed,
	input  logic                   i_is_slow,
	input  logic [`AUD_ADDR_W-1:0] i_end_addr,
	input  logic                   i_aud_bclk,
	input  logic                   i_aud_daclrck,
	input  logic                   i_rd_ready,
	input  logic [`AUD_DATA_W-1:0] i_rd_data,
	input  logic                   i_rd_rvalid,
	output logic                   o_rd_valid,
	output logic [`AUD_ADDR_W-1:0] o_rd_addr,
	output logic                   o_aud_dacdat,
	output logic                   o_play_done
);

	localparam int cnt_w = $clog2(`AUD_SLOT_BITS + 1);
	localparam logic [cnt_w-1:0] slot_bits = cnt_w'(`AUD_SLOT_BITS);

	logic [2:0]             bclk_sync;
	logic [2:0]             lrck_sync;
	logic                   bclk_fall;
	logic                   slot_start;
	logic [cnt_w-1:0]       bit_cnt;
	logic [`AUD_DATA_W-1:0] shift_q;
	logic [`AUD_DATA_W-1:0] buf_data;
	logic                   buf_valid;
	logic                   rd_busy;
	logic [`AUD_ADDR_W-1:0] play_addr;
	logic [`AUD_ADDR_W-1:0] next_addr;
	aud_speed_t             hold_cnt;
	logic                   playing;
	logic                   at_end;
	logic                   fetch;

	assign bclk_fall  = bclk_sync[2] & ~bclk_sync[1];
	assign slot_start = lrck_sync[2] & ~lrck_sync[1];
	assign playing    = (i_state == st_play);

	// nothing left to request, the buffered sample is the last one
	assign at_end = (play_addr >= i_end_addr);
	assign fetch  = slot_start && playing && !at_end && !rd_busy;

	// fast mode skips, slow mode repeats an address speed+1 times
	always_comb begin
		next_addr = play_addr;
		if (!i_is_slow) begin
			next_addr = play_addr + `AUD_ADDR_W'(i_speed) + 1'b1;
		end else if (hold_cnt == i_speed) begin
			next_addr = play_addr + 1'b1;
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			bclk_sync    <= '0;
			lrck_sync    <= '1;
			bit_cnt      <= slot_bits;
			shift_q      <= '0;
			o_aud_dacdat <= 1'b0;
			buf_valid    <= 1'b0;
			rd_busy      <= 1'b0;
			o_rd_valid   <= 1'b0;
			play_addr    <= '0;
			hold_cnt     <= '0;
			o_play_done  <= 1'b0;
		end else begin
			bclk_sync   <= {bclk_sync[1:0], i_aud_bclk};
			lrck_sync   <= {lrck_sync[1:0], i_aud_daclrck};
			o_play_done <= slot_start && playing && at_end;

			// serializer, msb goes out after the first falling edge of the slot
			if (slot_start) begin
				bit_cnt      <= '0;
				o_aud_dacdat <= 1'b0;
				shift_q      <= (playing && buf_valid) ? buf_data : '0;
			end else if (bclk_fall) begin
				if (bit_cnt < slot_bits) begin
					o_aud_dacdat <= shift_q[`AUD_DATA_W-1];
					shift_q      <= {shift_q[`AUD_DATA_W-2:0], 1'b0};
					bit_cnt      <= bit_cnt + 1'b1;
				end else begin
					o_aud_dacdat <= 1'b0;
				end
			end

			if (i_state == st_idle) begin
				buf_valid <= 1'b0;
			end else if (i_rd_rvalid) begin
				buf_valid <= 1'b1;
			end else if (slot_start && playing) begin
				buf_valid <= 1'b0;
			end

			if (fetch) begin
				rd_busy <= 1'b1;
			end else if (i_rd_rvalid) begin
				rd_busy <= 1'b0;
			end

			if (o_rd_valid && i_rd_ready) begin
				o_rd_valid <= 1'b0;
			end else if (fetch) begin
				o_rd_valid <= 1'b1;
			end

			// position survives pause, restarts from zero after idle
			if (i_state == st_idle) begin
				play_addr <= '0;
				hold_cnt  <= '0;
			end else if (fetch) begin
				play_addr <= next_addr;
				hold_cnt  <= (i_is_slow && (hold_cnt != i_speed)) ? hold_cnt + 1'b1 : '0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (fetch) begin
			o_rd_addr <= play_addr;
		end
		if (i_rd_rvalid) begin
			buf_data <= i_rd_data;
		end
	end

endmodule

// ==== logic/aud_recorder.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module aud_recorder import aud_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  aud_state_e             i_state,
	input  logic                   i_aud_bclk,
	input  logic                   i_aud_adclrck,
	input  logic                   i_aud_adcdat,
	input  logic                   i_wr_ready,
	output logic                   o_wr_valid,
	output logic [`AUD_ADDR_W-1:0] o_wr_addr,
	output logic [`AUD_DATA_W-1:0] o_wr_data,
	output logic [`AUD_ADDR_W-1:0] o_rec_addr
);

	localparam int cnt_w = $clog2(`AUD_SLOT_BITS + 2);
	localparam logic [cnt_w-1:0] slot_last = cnt_w'(`AUD_SLOT_BITS);

	logic [2:0]             bclk_sync;
	logic [2:0]             lrck_sync;
	logic [1:0]             dat_sync;
	logic                   bclk_rise;
	logic                   left_start;
	logic [cnt_w-1:0]       bit_cnt;
	logic [`AUD_DATA_W-1:0] shift_q;
	logic [`AUD_DATA_W-1:0] sample_word;
	logic                   slot_done;
	logic                   in_record_q;
	logic                   issue;
	logic                   wr_fire;
	logic [`AUD_ADDR_W-1:0] rec_cnt;

	assign bclk_rise   = bclk_sync[1] & ~bclk_sync[2];
	assign left_start  = lrck_sync[2] & ~lrck_sync[1];
	assign sample_word = {shift_q[`AUD_DATA_W-2:0], dat_sync[1]};

	// last data bit arrives on this rising edge, may already be in the right slot
	assign slot_done = bclk_rise && (bit_cnt == slot_last);

	// one write per left sample, only after a full cycle in record
	assign issue   = slot_done && (i_state == st_record) && in_record_q && !o_wr_valid;
	assign wr_fire = o_wr_valid && i_wr_ready;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			bclk_sync   <= '0;
			lrck_sync   <= '1;
			dat_sync    <= '0;
			bit_cnt     <= slot_last + 1'b1;
			in_record_q <= 1'b0;
			o_wr_valid  <= 1'b0;
			rec_cnt     <= '0;
		end else begin
			bclk_sync   <= {bclk_sync[1:0], i_aud_bclk};
			lrck_sync   <= {lrck_sync[1:0], i_aud_adclrck};
			dat_sync    <= {dat_sync[0], i_aud_adcdat};
			in_record_q <= (i_state == st_record);

			// counter parks past the slot so right-channel bits are ignored
			if (left_start) begin
				bit_cnt <= '0;
			end else if (bclk_rise && (bit_cnt <= slot_last)) begin
				bit_cnt <= bit_cnt + 1'b1;
			end

			if (wr_fire) begin
				o_wr_valid <= 1'b0;
			end else if (issue) begin
				o_wr_valid <= 1'b1;
			end

			if ((i_state == st_record) && !in_record_q) begin
				rec_cnt <= '0;
			end else if (wr_fire) begin
				rec_cnt <= rec_cnt + 1'b1;
			end
		end
	end

	// data path
	always_ff @(posedge i_clk) begin
		// first rising edge after lrck falls is the delay bit
		if (bclk_rise && (bit_cnt != '0) && (bit_cnt <= slot_last)) begin
			shift_q <= sample_word;
		end
		if (issue) begin
			o_wr_addr <= rec_cnt;
			o_wr_data <= sample_word;
		end
	end

	assign o_rec_addr = rec_cnt;

endmodule

// ==== logic/aud_ctrl.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module aud_ctrl import aud_pkg::*; (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_key_record,
	input  logic                   i_key_play,
	input  logic                   i_key_stop,
	input  logic [`AUD_ADDR_W-1:0] i_rec_addr,
	input  logic                   i_play_done,
	output aud_state_e             o_state,
	output logic [`AUD_ADDR_W-1:0] o_end_addr
);

	aud_state_e state_q;
	aud_state_e state_d;
	logic       mem_full;
	logic       rec_leave;

	// top address reached, no room left for another sample
	assign mem_full = (i_rec_addr == {`AUD_ADDR_W{1'b1}});

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (i_key_record) begin
					state_d = st_record;
				end else if (i_key_play) begin
					state_d = st_play;
				end
			end
			st_record: begin
				if (i_key_stop || mem_full) begin
					state_d = st_idle;
				end
			end
			st_play: begin
				// stop wins over a simultaneous play key
				if (i_key_stop || i_play_done) begin
					state_d = st_idle;
				end else if (i_key_play) begin
					state_d = st_pause;
				end
			end
			st_pause: begin
				if (i_key_stop) begin
					state_d = st_idle;
				end else if (i_key_play) begin
					state_d = st_play;
				end
			end
			default: state_d = st_idle;
		endcase
	end

	assign rec_leave = (state_q == st_record) && (state_d != st_record);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q    <= st_idle;
			o_end_addr <= '0;
		end else begin
			state_q <= state_d;
			// recording length = samples written so far
			if (rec_leave) begin
				o_end_addr <= i_rec_addr;
			end
		end
	end

	assign o_state = state_q;

endmodule

// ==== logic/aud_pkg.sv ====
package aud_pkg;

	// operating mode of the recorder/player
	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_record = 2'd1,
		st_play   = 2'd2,
		st_pause  = 2'd3
	} aud_state_e;

	// speed factor minus one, 0..7 stands for 1x..8x
	typedef logic [2:0] aud_speed_t;

endpackage

// ==== logic/aud_defines.svh ====
`ifndef AUD_DEFINES_SVH
`define AUD_DEFINES_SVH

// sram word address width
`define AUD_ADDR_W 20

// sample width, same as the sram word
`define AUD_DATA_W 16

// bit clocks in one i2s channel slot
`define AUD_SLOT_BITS 16

`endif
